/* Makefile */
TOP = align_mem_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal -f align_mem.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

/* align_mem.f */
+incdir+src
src/align_mem_pkg.sv
src/align_req_stage.sv
src/align_sram_array.sv
src/align_rsp_stage.sv
src/align_mem_top.sv
tb/align_mem_checker.sv
tb/align_mem_tb.sv

/* src/align_mem_defs.svh */
`ifndef ALIGN_MEM_DEFS_SVH
`define ALIGN_MEM_DEFS_SVH

// logical word, and the stored word with its parity bit.
`define ALIGN_WIDTH 32
`define ALIGN_MEMWDTH 33

// virtual banks seen by the user.
`define ALIGN_NUMVBNK 4
`define ALIGN_BITVBNK 2

// virtual rows per bank.
`define ALIGN_NUMVROW 48
`define ALIGN_BITVROW 6

// words packed side by side into one physical row.
`define ALIGN_NUMWRDS 3
`define ALIGN_BITWRDS 2

`define ALIGN_NUMSROW 16   // 48 / 3 physical rows per bank.
`define ALIGN_BITSROW 4

`define ALIGN_SRAM_DELAY 2 // read latency of the array in cycles.

`endif

/* src/align_mem_pkg.sv */
`include "align_mem_defs.svh"

package align_mem_pkg;

  typedef logic [`ALIGN_WIDTH-1:0] word_t;

  typedef struct packed {
    logic [`ALIGN_BITVBNK-1:0] bnk;
    logic [`ALIGN_BITVROW-1:0] vrow;
  } vaddr_t;

  // physical address reported back with each read.
  typedef struct packed {
    logic [`ALIGN_BITWRDS-1:0] word;
    logic [`ALIGN_BITSROW-1:0] srow;
  } paddr_t;

  typedef struct packed {
    logic                                      vld;
    logic [`ALIGN_BITVBNK-1:0]                 bnk;
    logic [`ALIGN_BITSROW-1:0]                 srow;
    logic [`ALIGN_NUMWRDS*`ALIGN_MEMWDTH-1:0]  bw;  // one enable per stored bit.
    logic [`ALIGN_NUMWRDS*`ALIGN_MEMWDTH-1:0]  din;
  } mem_wr_t;

  typedef struct packed {
    logic                      vld;
    logic [`ALIGN_BITVBNK-1:0] bnk;
    logic [`ALIGN_BITSROW-1:0] srow;
  } mem_rd_t;

  typedef struct packed {
    logic   vld;
    paddr_t pa;
  } rd_ctx_t;

  typedef struct packed {
    logic   vld;
    word_t  data;
    logic   serr;
    paddr_t padr;
  } rd_rsp_t;

endpackage

/* src/align_mem_top.sv */
`timescale 1ns/1ps
`include "align_mem_defs.svh"

module align_mem_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   write,
  input  align_mem_pkg::vaddr_t  wr_addr,
  input  align_mem_pkg::word_t   din,
  input  logic                   poison,
  input  logic                   read,
  input  align_mem_pkg::vaddr_t  rd_addr,
  output align_mem_pkg::rd_rsp_t rsp
);
  import align_mem_pkg::*;

  mem_wr_t                                  mem_wr;
  mem_rd_t                                  mem_rd;
  rd_ctx_t                                  rd_ctx;
  logic [`ALIGN_NUMWRDS*`ALIGN_MEMWDTH-1:0] mem_dout;
  rd_ctx_t                                  dout_ctx;

  align_req_stage u_req (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_addr (wr_addr),
    .din     (din),
    .poison  (poison),
    .read    (read),
    .rd_addr (rd_addr),
    .mem_wr  (mem_wr),
    .mem_rd  (mem_rd),
    .rd_ctx  (rd_ctx)
  );

  align_sram_array u_sram (
    .clk      (clk),
    .rst      (rst),
    .mem_wr   (mem_wr),
    .mem_rd   (mem_rd),
    .rd_ctx   (rd_ctx),
    .mem_dout (mem_dout),
    .dout_ctx (dout_ctx)
  );

  align_rsp_stage u_rsp (
    .clk      (clk),
    .rst      (rst),
    .mem_dout (mem_dout),
    .dout_ctx (dout_ctx),
    .rsp      (rsp)
  );

endmodule

/* src/align_req_stage.sv */
`timescale 1ns/1ps
`include "align_mem_defs.svh"

module align_req_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   write,
  input  align_mem_pkg::vaddr_t  wr_addr,
  input  align_mem_pkg::word_t   din,
  input  logic                   poison,
  input  logic                   read,
  input  align_mem_pkg::vaddr_t  rd_addr,
  output align_mem_pkg::mem_wr_t mem_wr,
  output align_mem_pkg::mem_rd_t mem_rd,
  output align_mem_pkg::rd_ctx_t rd_ctx
);
  import align_mem_pkg::*;

  localparam logic [`ALIGN_BITVROW-1:0] slot_cnt = `ALIGN_BITVROW'(`ALIGN_NUMWRDS);

  // the quotient picks the physical row, the remainder picks the slot inside it.
  function automatic paddr_t map_vrow(input logic [`ALIGN_BITVROW-1:0] vrow);
    logic [`ALIGN_BITVROW-1:0] quo;
    logic [`ALIGN_BITVROW-1:0] rem;
    paddr_t                    pa;
    quo = vrow / slot_cnt;
    rem = vrow % slot_cnt;
    pa.word = rem[`ALIGN_BITWRDS-1:0];
    pa.srow = quo[`ALIGN_BITSROW-1:0];
    return pa;
  endfunction

  paddr_t                    wr_pa;
  paddr_t                    rd_pa;
  logic [`ALIGN_MEMWDTH-1:0] wr_word;
  mem_wr_t                   wr_next;

  assign wr_pa = map_vrow(wr_addr.vrow);
  assign rd_pa = map_vrow(rd_addr.vrow);

  // even parity, so a clean word XORs to zero. poison flips the parity bit.
  assign wr_word = {(^din) ^ poison, din};

  always_comb begin
    wr_next.vld  = write;
    wr_next.bnk  = wr_addr.bnk;
    wr_next.srow = wr_pa.srow;
    wr_next.bw   = '0;
    wr_next.din  = '0;
    for (int i = 0; i < `ALIGN_NUMWRDS; i++) begin
      if (wr_pa.word == `ALIGN_BITWRDS'(i)) begin
        wr_next.bw[i*`ALIGN_MEMWDTH +: `ALIGN_MEMWDTH]  = '1;
        wr_next.din[i*`ALIGN_MEMWDTH +: `ALIGN_MEMWDTH] = wr_word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr.vld <= 1'b0;
      mem_rd.vld <= 1'b0;
      rd_ctx.vld <= 1'b0;
    end else begin
      mem_wr.vld <= wr_next.vld;
      mem_rd.vld <= read;
      rd_ctx.vld <= read;
    end
    if (write) begin
      mem_wr.bnk  <= wr_next.bnk;
      mem_wr.srow <= wr_next.srow;
      mem_wr.bw   <= wr_next.bw;
      mem_wr.din  <= wr_next.din;
    end
    if (read) begin
      mem_rd.bnk  <= rd_addr.bnk;
      mem_rd.srow <= rd_pa.srow;
      rd_ctx.pa   <= rd_pa;  // the slot is needed again on the way back.
    end
  end

endmodule

/* src/align_rsp_stage.sv */
`timescale 1ns/1ps
`include "align_mem_defs.svh"

module align_rsp_stage (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [`ALIGN_NUMWRDS*`ALIGN_MEMWDTH-1:0] mem_dout,
  input  align_mem_pkg::rd_ctx_t                   dout_ctx,
  output align_mem_pkg::rd_rsp_t                   rsp
);
  import align_mem_pkg::*;

  logic [`ALIGN_MEMWDTH-1:0] slot_word;
  rd_rsp_t                   rsp_next;

  // pick the word the context points at out of the full physical row.
  always_comb begin
    slot_word = '0;
    for (int i = 0; i < `ALIGN_NUMWRDS; i++) begin
      if (dout_ctx.pa.word == `ALIGN_BITWRDS'(i)) begin
        slot_word = mem_dout[i*`ALIGN_MEMWDTH +: `ALIGN_MEMWDTH];
      end
    end
  end

  always_comb begin
    rsp_next.vld  = dout_ctx.vld;
    rsp_next.data = slot_word[`ALIGN_WIDTH-1:0];
    rsp_next.serr = ^slot_word;  // any odd count of ones is an error.
    rsp_next.padr = dout_ctx.pa;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp.vld <= 1'b0;
    end else begin
      rsp.vld <= rsp_next.vld;
    end
    if (rsp_next.vld) begin
      rsp.data <= rsp_next.data;
      rsp.serr <= rsp_next.serr;
      rsp.padr <= rsp_next.padr;
    end
  end

endmodule

/* src/align_sram_array.sv */
`timescale 1ns/1ps
`include "align_mem_defs.svh"

module align_sram_array (
  input  logic                                     clk,
  input  logic                                     rst,
  input  align_mem_pkg::mem_wr_t                   mem_wr,
  input  align_mem_pkg::mem_rd_t                   mem_rd,
  input  align_mem_pkg::rd_ctx_t                   rd_ctx,
  output logic [`ALIGN_NUMWRDS*`ALIGN_MEMWDTH-1:0] mem_dout,
  output align_mem_pkg::rd_ctx_t                   dout_ctx
);
  import align_mem_pkg::*;

  localparam int row_w = `ALIGN_NUMWRDS * `ALIGN_MEMWDTH;
  localparam int delay = `ALIGN_SRAM_DELAY;

  logic [row_w-1:0] mem [`ALIGN_NUMVBNK][`ALIGN_NUMSROW];
  logic [row_w-1:0] wr_old;
  logic [row_w-1:0] wr_row;

  // the read delay line carries data and context side by side.
  logic [row_w-1:0] dout_q [delay];
  paddr_t           pa_q [delay];
  logic [delay-1:0] vld_q;

  assign wr_old = mem[mem_wr.bnk][mem_wr.srow];

  // only enabled bits change, so the neighbouring slots of the row survive.
  assign wr_row = (mem_wr.bw & mem_wr.din) | (~mem_wr.bw & wr_old);

  always_ff @(posedge clk) begin
    if (mem_wr.vld) begin
      mem[mem_wr.bnk][mem_wr.srow] <= wr_row;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rd.vld) begin
      dout_q[0] <= mem[mem_rd.bnk][mem_rd.srow];
    end
    pa_q[0] <= rd_ctx.pa;
    for (int i = 1; i < delay; i++) begin
      dout_q[i] <= dout_q[i-1];
      pa_q[i]   <= pa_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= rd_ctx.vld;
      for (int i = 1; i < delay; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  assign mem_dout     = dout_q[delay-1];
  assign dout_ctx.vld = vld_q[delay-1];
  assign dout_ctx.pa  = pa_q[delay-1];

endmodule

/* tb/align_mem_checker.sv */
`timescale 1ns/1ps
`include "align_mem_defs.svh"

module align_mem_checker (
  input logic                   clk,
  input logic                   rst,
  input logic                   write,
  input align_mem_pkg::vaddr_t  wr_addr,
  input align_mem_pkg::word_t   din,
  input logic                   poison,
  input logic                   read,
  input align_mem_pkg::vaddr_t  rd_addr,
  input align_mem_pkg::rd_rsp_t rsp
);
  import align_mem_pkg::*;

  localparam int     rd_latency  = 4;
  localparam vaddr_t shadow_addr = '{bnk: 2'd2, vrow: 6'd7};
  localparam paddr_t shadow_pa   = '{word: 2'd1, srow: 4'd2};  // 7 % 3 and 7 / 3.

  logic  shadow_vld;
  word_t shadow_data;
  logic  shadow_poison;
  logic  shadow_hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      shadow_vld <= 1'b0;
    end else if (write && wr_addr == shadow_addr) begin
      shadow_vld <= 1'b1;
    end
    if (write && wr_addr == shadow_addr) begin
      shadow_data   <= din;
      shadow_poison <= poison;
    end
  end

  assign shadow_hit = read && (rd_addr == shadow_addr) && shadow_vld;

  // the bank field spans exactly the banks, so only the row can leave the range.
  wr_addr_in_range: assert property (@(posedge clk) disable iff (rst)
    write |-> int'(wr_addr.vrow) < `ALIGN_NUMVROW)
    else $error("write address out of range");

  rd_addr_in_range: assert property (@(posedge clk) disable iff (rst)
    read |-> int'(rd_addr.vrow) < `ALIGN_NUMVROW)
    else $error("read address out of range");

  no_bank_conflict: assert property (@(posedge clk) disable iff (rst)
    !(read && write && rd_addr.bnk == wr_addr.bnk))
    else $error("read and write to the same bank in one cycle");

  // every response belongs to the read four edges back, and no other.
  rsp_follows_read: assert property (@(posedge clk) disable iff (rst)
    rsp.vld == $past(read, rd_latency))
    else $error("response valid does not line up with a read");

  shadow_readback: assert property (@(posedge clk) disable iff (rst)
    (rsp.vld && $past(shadow_hit, rd_latency)) |->
      (rsp.data == $past(shadow_data, rd_latency) &&
       rsp.serr == $past(shadow_poison, rd_latency) &&
       rsp.padr == shadow_pa))
    else $error("shadowed address returned the wrong word");

endmodule

/* tb/align_mem_tb.sv */
`timescale 1ns/1ps
`include "align_mem_defs.svh"

module align_mem_tb;
  import align_mem_pkg::*;

  localparam int reset_cycles  = 16;
  localparam int idle_cycles   = 6;
  localparam int burst_len     = 20;
  localparam int rand_cycles   = 400;
  localparam int rd_latency    = 4;
  localparam int num_ops       = idle_cycles + 1 + 6 + 4 + burst_len + rand_cycles;
  localparam int timeout_limit = num_ops + reset_cycles + 64;

  typedef struct packed {
    logic    known;  // data is only defined once the word was written.
    int      issued;
    vaddr_t  addr;
    rd_rsp_t rsp;
  } expect_t;

  logic    clk = 1'b0;
  logic    rst;
  logic    write;
  vaddr_t  wr_addr;
  word_t   din;
  logic    poison;
  logic    read;
  vaddr_t  rd_addr;
  rd_rsp_t rsp;

  logic [15:0] lfsr;
  int          cycle_cnt = 0;
  int          data_errs = 0;
  int          serr_errs = 0;
  int          padr_errs = 0;
  int          other_errs = 0;
  expect_t     exp_q [$];

  word_t model_data    [`ALIGN_NUMVBNK][`ALIGN_NUMVROW];
  logic  model_poison  [`ALIGN_NUMVBNK][`ALIGN_NUMVROW];
  logic  model_written [`ALIGN_NUMVBNK][`ALIGN_NUMVROW];

  align_mem_top u_align_mem_top (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_addr (wr_addr),
    .din     (din),
    .poison  (poison),
    .read    (read),
    .rd_addr (rd_addr),
    .rsp     (rsp)
  );

  bind align_mem_top align_mem_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_addr (wr_addr),
    .din     (din),
    .poison  (poison),
    .read    (read),
    .rd_addr (rd_addr),
    .rsp     (rsp)
  );

  always #10 clk = ~clk;

  // the feedback follows x^16 + x^14 + x^13 + x^11 + 1 and steps once per bit handed out.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic vaddr_t make_addr(input int bnk, input int vrow);
    vaddr_t a;
    a.bnk  = `ALIGN_BITVBNK'(bnk);
    a.vrow = `ALIGN_BITVROW'(vrow);
    return a;
  endfunction

  function automatic vaddr_t random_addr();
    int bnk;
    int vrow;
    bnk  = int'(rand_bits(`ALIGN_BITVBNK));
    vrow = int'(rand_bits(`ALIGN_BITVROW)) % `ALIGN_NUMVROW;
    return make_addr(bnk, vrow);
  endfunction

  // three words share a physical row, so quotient is the row and remainder the slot.
  function automatic paddr_t expected_padr(input vaddr_t a);
    paddr_t pa;
    pa.srow = `ALIGN_BITSROW'(int'(a.vrow) / `ALIGN_NUMWRDS);
    pa.word = `ALIGN_BITWRDS'(int'(a.vrow) % `ALIGN_NUMWRDS);
    return pa;
  endfunction

  task automatic check_data(input word_t got, input word_t exp, input vaddr_t a);
    if (got !== exp) begin
      $display("mismatch at %0t: data of bank %0d row %0d is 0x%08h, expected 0x%08h",
               $time, a.bnk, a.vrow, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_serr(input logic got, input logic exp, input vaddr_t a);
    if (got !== exp) begin
      $display("mismatch at %0t: serr of bank %0d row %0d is %b, expected %b",
               $time, a.bnk, a.vrow, got, exp);
      serr_errs++;
    end
  endtask

  // the physical address prints as srow.word.
  task automatic check_padr(input paddr_t got, input paddr_t exp, input vaddr_t a);
    if (got !== exp) begin
      $display("mismatch at %0t: padr of bank %0d row %0d is %0d.%0d, expected %0d.%0d",
               $time, a.bnk, a.vrow, got.srow, got.word, exp.srow, exp.word);
      padr_errs++;
    end
  endtask

  task automatic drive_cycle(input logic wr, input vaddr_t wa, input word_t wd, input logic wp,
                             input logic rd, input vaddr_t ra);
    expect_t e;
    @(negedge clk);
    write   = wr;
    wr_addr = wa;
    din     = wd;
    poison  = wp;
    read    = rd;
    rd_addr = ra;
    if (rd) begin
      e.known    = model_written[ra.bnk][ra.vrow];
      e.issued   = cycle_cnt;
      e.addr     = ra;
      e.rsp.vld  = 1'b1;
      e.rsp.data = model_data[ra.bnk][ra.vrow];
      e.rsp.serr = e.known ? model_poison[ra.bnk][ra.vrow] : 1'b0;
      e.rsp.padr = expected_padr(ra);
      exp_q.push_back(e);
    end
    if (wr) begin
      model_data[wa.bnk][wa.vrow]    = wd;
      model_poison[wa.bnk][wa.vrow]  = wp;
      model_written[wa.bnk][wa.vrow] = 1'b1;
    end
  endtask

  task automatic drive_idle();
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic drain_responses();
    while (exp_q.size() != 0) begin
      drive_idle();
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Test failed");
      $finish;
    end
  end

  always @(posedge clk) begin
    expect_t e;
    if (!rst && rsp.vld) begin
      if (exp_q.size() == 0) begin
        $display("response at %0t arrived with no read outstanding", $time);
        other_errs++;
      end else begin
        e = exp_q.pop_front();
        if (cycle_cnt - e.issued != rd_latency) begin
          $display("response at %0t came %0d cycles after its read instead of %0d",
                   $time, cycle_cnt - e.issued, rd_latency);
          other_errs++;
        end
        if (e.known) begin
          check_data(rsp.data, e.rsp.data, e.addr);
        end
        check_serr(rsp.serr, e.rsp.serr, e.addr);
        check_padr(rsp.padr, e.rsp.padr, e.addr);
      end
    end
  end

  initial begin
    vaddr_t wa;
    vaddr_t ra;
    vaddr_t prev_wa;
    logic   prev_wr;
    logic   wr;
    logic   rd;
    logic   wp;
    word_t  wd;
    lfsr    = 16'd42;
    rst     = 1'b1;
    write   = 1'b0;
    wr_addr = '0;
    din     = '0;
    poison  = 1'b0;
    read    = 1'b0;
    rd_addr = '0;
    prev_wr = 1'b0;
    prev_wa = '0;
    for (int b = 0; b < `ALIGN_NUMVBNK; b++) begin
      for (int r = 0; r < `ALIGN_NUMVROW; r++) begin
        model_written[b][r] = 1'b0;
      end
    end
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;

    // quiet pipeline first, then a single read to time the response.
    repeat (idle_cycles) drive_idle();
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, make_addr(0, 5));
    drain_responses();

    // all three slots of bank 2 physical row 2.
    drive_cycle(1'b1, make_addr(2, 6), 32'h1111_aaaa, 1'b0, 1'b0, '0);
    drive_cycle(1'b1, make_addr(2, 7), 32'h2222_5555, 1'b0, 1'b0, '0);
    drive_cycle(1'b1, make_addr(2, 8), 32'h3333_f0f0, 1'b0, 1'b0, '0);
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, make_addr(2, 6));
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, make_addr(2, 7));
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, make_addr(2, 8));
    drain_responses();

    drive_cycle(1'b1, make_addr(1, 20), 32'hdead_beef, 1'b1, 1'b0, '0);
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, make_addr(1, 20));
    drive_cycle(1'b1, make_addr(1, 20), 32'h0bad_cafe, 1'b0, 1'b0, '0);
    drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, make_addr(1, 20));
    drain_responses();

    for (int i = 0; i < burst_len; i++) begin
      drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, make_addr(i % 4, (i * 5) % `ALIGN_NUMVROW));
    end
    drain_responses();

    for (int n = 0; n < rand_cycles; n++) begin
      wr = 1'(rand_bits(1));
      rd = 1'(rand_bits(1));
      wa = random_addr();
      wd = rand_bits(`ALIGN_WIDTH);
      wp = (2'(rand_bits(2)) == 2'b11);
      ra = random_addr();
      if (prev_wr && 2'(rand_bits(2)) == 2'b00) begin
        ra = prev_wa;  // read back the word written one cycle ago.
      end
      if (wr && rd && wa.bnk == ra.bnk) begin
        wa.bnk = ra.bnk + 1'b1;
      end
      drive_cycle(wr, wa, wd, wp, rd, ra);
      prev_wr = wr;
      prev_wa = wa;
    end
    drain_responses();

    if (exp_q.size() != 0) begin
      $display("%0d reads never received a response", exp_q.size());
      other_errs++;
    end
    $display("errors: data %0d, serr %0d, padr %0d, other %0d",
             data_errs, serr_errs, padr_errs, other_errs);
    if (data_errs + serr_errs + padr_errs + other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
